// File: rtl/bpu_pkg.sv
// Branch predictor widths, table geometry, vector types and record structs
`default_nettype none

package bpu_pkg;

   // Address and table geometry
   localparam int PC_W      = 32;
   localparam int PHT_AW    = 6;
   localparam int BTB_AW    = 4;
   localparam int BTB_TAG_W = PC_W - BTB_AW;

   typedef logic [PC_W-1:0]   pc_t;
   typedef logic [PHT_AW-1:0] pht_idx_t;
   typedef logic [BTB_AW-1:0] btb_idx_t;
   typedef logic [1:0]        pht_cnt_t;

   // Weakly not taken
   localparam pht_cnt_t PHT_CNT_INIT = 2'd1;

   typedef struct packed {
      logic                 valid;
      logic                 is_bcc;
      logic [BTB_TAG_W-1:0] tag;
      pc_t                  target;
   } btb_entry_t;

   // Carried by fetch from lookup to resolve
   typedef struct packed {
      pht_cnt_t pht_cnt;
      pht_idx_t pht_idx;
      btb_idx_t btb_idx;
      pc_t      pred_tgt;
      logic     pred_taken;
   } bpu_upd_t;

   // One resolved branch from an execution unit
   typedef struct packed {
      logic     is_bcc;
      logic     is_breg;
      logic     is_brel;
      logic     taken;
      pc_t      pc;
      pc_t      npc_act;
      bpu_upd_t upd;
   } bpu_res_t;

endpackage

`default_nettype wire

// File: rtl/bpu_predict.sv
// Lookup stage with index hashing, BTB tag compare and taken decision
`default_nettype none

module bpu_predict import bpu_pkg::*; #(
   parameter int FETCH_LANES = 2
) (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             req_valid,
   output logic                             req_ready,
   input  pc_t        [FETCH_LANES-1:0]     req_pc,
   output logic                             pred_valid,
   input  logic                             pred_ready,
   output pc_t        [FETCH_LANES-1:0]     pred_npc,
   output logic       [FETCH_LANES-1:0]     pred_taken,
   output bpu_upd_t   [FETCH_LANES-1:0]     pred_upd,
   input  pht_idx_t                         ghr,
   output logic                             tbl_re,
   output pht_idx_t   [FETCH_LANES-1:0]     pht_raddr,
   input  pht_cnt_t   [FETCH_LANES-1:0]     pht_rdata,
   output btb_idx_t   [FETCH_LANES-1:0]     btb_raddr,
   input  btb_entry_t [FETCH_LANES-1:0]     btb_rdata
);

   pc_t      [FETCH_LANES-1:0] s1_pc;
   pht_idx_t [FETCH_LANES-1:0] s1_pht_idx;
   btb_idx_t [FETCH_LANES-1:0] s1_btb_idx;
   logic     [FETCH_LANES-1:0] lane_hit;

   // A new lookup may enter when the output slot frees up this cycle
   assign req_ready = !pred_valid || pred_ready;
   assign tbl_re    = req_valid && req_ready;

   // Gshare hash for the PHT, plain low bits for the BTB
   always_comb
   begin
      for (int i = 0; i < FETCH_LANES; i++)
      begin
         pht_raddr[i] = req_pc[i][PHT_AW-1:0] ^ ghr;
         btb_raddr[i] = req_pc[i][BTB_AW-1:0];
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         pred_valid <= 1'b0;
      else if (tbl_re)
         pred_valid <= 1'b1;
      else if (pred_ready)
         pred_valid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (tbl_re)
      begin
         s1_pc      <= req_pc;
         s1_pht_idx <= pht_raddr;
         s1_btb_idx <= btb_raddr;
      end
   end

   // Stage 2 decode of the table read data
   always_comb
   begin
      for (int i = 0; i < FETCH_LANES; i++)
      begin
         lane_hit[i]   = btb_rdata[i].valid &&
                         (btb_rdata[i].tag == s1_pc[i][PC_W-1:BTB_AW]);
         // Jumps always taken on hit, branches follow the counter
         pred_taken[i] = lane_hit[i] && (!btb_rdata[i].is_bcc || (pht_rdata[i] >= 2'd2));
         pred_npc[i]   = btb_rdata[i].target;
         pred_upd[i]   = '{pht_cnt:    pht_rdata[i],
                           pht_idx:    s1_pht_idx[i],
                           btb_idx:    s1_btb_idx[i],
                           pred_tgt:   btb_rdata[i].target,
                           pred_taken: pred_taken[i]};
      end
   end

   // Stalled prediction must not move, tables and stage 1 hold together
   a_pred_hold: assert property (@(posedge clk) disable iff (!rst_n)
      pred_valid && !pred_ready |=> pred_valid && $stable(pred_npc) &&
                                    $stable(pred_taken) && $stable(pred_upd));

endmodule

`default_nettype wire

// File: rtl/bpu_top.sv
// Branch prediction unit top with predictor, PHT, BTB, arbiter and update
`default_nettype none

module bpu_top import bpu_pkg::*; #(
   parameter int FETCH_LANES = 2
) (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           req_valid,
   output logic                           req_ready,
   input  pc_t      [FETCH_LANES-1:0]     req_pc,
   output logic                           pred_valid,
   input  logic                           pred_ready,
   output pc_t      [FETCH_LANES-1:0]     pred_npc,
   output logic     [FETCH_LANES-1:0]     pred_taken,
   output bpu_upd_t [FETCH_LANES-1:0]     pred_upd,
   input  logic                           res0_valid,
   output logic                           res0_ready,
   input  bpu_res_t                       res0,
   input  logic                           res1_valid,
   output logic                           res1_ready,
   input  bpu_res_t                       res1
);

   logic                          tbl_re;
   pht_idx_t   [FETCH_LANES-1:0]  pht_raddr;
   pht_cnt_t   [FETCH_LANES-1:0]  pht_rdata;
   btb_idx_t   [FETCH_LANES-1:0]  btb_raddr;
   btb_entry_t [FETCH_LANES-1:0]  btb_rdata;
   pht_idx_t                      ghr;
   logic                          wr_valid;
   bpu_res_t                      wr;
   logic                          pht_we;
   pht_idx_t                      pht_waddr;
   pht_cnt_t                      pht_wdata;
   logic                          btb_we;
   btb_idx_t                      btb_waddr;
   btb_entry_t                    btb_wdata;

   bpu_predict #(.FETCH_LANES(FETCH_LANES)) u_predict (
      .clk, .rst_n,
      .req_valid, .req_ready, .req_pc,
      .pred_valid, .pred_ready, .pred_npc, .pred_taken, .pred_upd,
      .ghr, .tbl_re,
      .pht_raddr, .pht_rdata, .btb_raddr, .btb_rdata
   );

   // Pattern history table of 2-bit counters
   pred_table #(
      .DATA_W(2), .ADDR_W(PHT_AW), .READ_PORTS(FETCH_LANES), .RESET_VAL(PHT_CNT_INIT)
   ) u_pht (
      .clk, .rst_n,
      .re({FETCH_LANES{tbl_re}}), .raddr(pht_raddr), .rdata(pht_rdata),
      .we(pht_we), .waddr(pht_waddr), .wdata(pht_wdata)
   );

   pred_table #(
      .DATA_W($bits(btb_entry_t)), .ADDR_W(BTB_AW), .READ_PORTS(FETCH_LANES), .RESET_VAL('0)
   ) u_btb (
      .clk, .rst_n,
      .re({FETCH_LANES{tbl_re}}), .raddr(btb_raddr), .rdata(btb_rdata),
      .we(btb_we), .waddr(btb_waddr), .wdata(btb_wdata)
   );

   res_arbiter u_arb (
      .clk, .rst_n,
      .res0_valid, .res0_ready, .res0,
      .res1_valid, .res1_ready, .res1,
      .wr_valid, .wr
   );

   bpu_update u_update (
      .clk, .rst_n, .wr_valid, .wr,
      .pht_we, .pht_waddr, .pht_wdata,
      .btb_we, .btb_waddr, .btb_wdata, .ghr
   );

endmodule

`default_nettype wire

// File: rtl/bpu_update.sv
// Resolve update with counter step, BTB entry build and global history
`default_nettype none

module bpu_update import bpu_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       wr_valid,
   input  bpu_res_t   wr,
   output logic       pht_we,
   output pht_idx_t   pht_waddr,
   output pht_cnt_t   pht_wdata,
   output logic       btb_we,
   output btb_idx_t   btb_waddr,
   output btb_entry_t btb_wdata,
   output pht_idx_t   ghr
);

   pht_cnt_t cnt_org;
   logic     is_jump;

   assign cnt_org = wr.upd.pht_cnt;
   assign is_jump = wr.is_breg || wr.is_brel;

   // Counter update for conditional branches only
   assign pht_we    = wr_valid && wr.is_bcc;
   assign pht_waddr = wr.upd.pht_idx;

   always_comb
   begin
      if (wr.taken)
      begin
         if (cnt_org == 2'd3)
            pht_wdata = 2'd3;
         else
            pht_wdata = cnt_org + 2'd1;
      end
      else
      begin
         if (cnt_org == 2'd0)
            pht_wdata = 2'd0;
         else
            pht_wdata = cnt_org - 2'd1;
      end
   end

   // Target refresh on jumps, direct overwrite
   assign btb_we    = wr_valid && is_jump;
   assign btb_waddr = wr.upd.btb_idx;
   assign btb_wdata = '{valid:  1'b1,
                        is_bcc: wr.is_bcc,
                        tag:    wr.pc[PC_W-1:BTB_AW],
                        target: wr.npc_act};

   // Newest outcome enters at bit 0
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         ghr <= '0;
      else if (pht_we)
         ghr <= {ghr[PHT_AW-2:0], wr.taken};
   end

endmodule

`default_nettype wire

// File: rtl/pred_table.sv
// Multi-read, single-write register file table with reset fill value
`default_nettype none

module pred_table #(
   parameter int                DATA_W     = 2,
   parameter int                ADDR_W     = 6,
   parameter int                READ_PORTS = 2,
   parameter logic [DATA_W-1:0] RESET_VAL  = '0
) (
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic [READ_PORTS-1:0]                re,
   input  logic [READ_PORTS-1:0][ADDR_W-1:0]    raddr,
   output logic [READ_PORTS-1:0][DATA_W-1:0]    rdata,
   input  logic                                 we,
   input  logic [ADDR_W-1:0]                    waddr,
   input  logic [DATA_W-1:0]                    wdata
);

   localparam int DEPTH = 1 << ADDR_W;

   logic [DATA_W-1:0] mem [DEPTH];

   // Table contents, cleared to the fill value
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < DEPTH; i++)
            mem[i] <= RESET_VAL;
      end
      else if (we)
      begin
         mem[waddr] <= wdata;
      end
   end

   // Registered read ports, a same-edge write is not forwarded
   always_ff @(posedge clk)
   begin
      for (int p = 0; p < READ_PORTS; p++)
      begin
         if (re[p])
            rdata[p] <= mem[raddr[p]];
      end
   end

endmodule

`default_nettype wire

// File: rtl/res_arbiter.sv
// Round-robin arbiter of two resolve ports onto the table write port
`default_nettype none

module res_arbiter import bpu_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     res0_valid,
   output logic     res0_ready,
   input  bpu_res_t res0,
   input  logic     res1_valid,
   output logic     res1_ready,
   input  bpu_res_t res1,
   output logic     wr_valid,
   output bpu_res_t wr
);

   // Low prefers res0
   logic prio;
   logic both_valid;

   assign both_valid = res0_valid && res1_valid;

   always_comb
   begin
      if (both_valid)
      begin
         res0_ready = !prio;
         res1_ready = prio;
      end
      else
      begin
         res0_ready = res0_valid;
         res1_ready = res1_valid;
      end
   end

   assign wr_valid = res0_ready || res1_ready;
   assign wr       = res1_ready ? res1 : res0;

   // Flip only on contention
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         prio <= 1'b0;
      else if (both_valid)
         prio <= !prio;
   end

   a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
      !(res0_ready && res1_ready));

   // Losers keep their request parked
   a_res0_hold: assert property (@(posedge clk) disable iff (!rst_n)
      res0_valid && !res0_ready |=> res0_valid && $stable(res0));
   a_res1_hold: assert property (@(posedge clk) disable iff (!rst_n)
      res1_valid && !res1_ready |=> res1_valid && $stable(res1));

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build the branch predictor testbench with Verilator, run it and scan the log

set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module bpu_tb -f vlog.f -o bpu_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/bpu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
   echo "Result: failure, see $LOG"
   exit 1
fi

echo "Result: success"
exit 0

// File: tb/bpu_tb.sv
// Branch predictor testbench with random traffic, table model, checks and watchdog
`default_nettype none

module bpu_tb import bpu_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int LANES      = 2;
   localparam int SEED       = 26;
   localparam int NUM_TESTS  = 6;
   localparam int TOTAL_CYC  = 40 + 150 + 300 + 200 + 300 + 3000;
   localparam int WD_CYCLES  = TOTAL_CYC * 4 + 1000;
   localparam int POOL_DEPTH = 40;

   // One expected prediction, fixed at the accept edge
   typedef struct packed {
      pc_t      [LANES-1:0] pc;
      pc_t      [LANES-1:0] npc;
      bpu_upd_t [LANES-1:0] upd;
   } exp_t;

   logic                   clk;
   logic                   rst_n;
   logic                   req_valid;
   logic                   req_ready;
   pc_t      [LANES-1:0]   req_pc;
   logic                   pred_valid;
   logic                   pred_ready;
   pc_t      [LANES-1:0]   pred_npc;
   logic     [LANES-1:0]   pred_taken;
   bpu_upd_t [LANES-1:0]   pred_upd;
   logic                   res0_valid;
   logic                   res0_ready;
   bpu_res_t               res0;
   logic                   res1_valid;
   logic                   res1_ready;
   bpu_res_t               res1;

   // Reference state of the predictor
   pht_cnt_t   pht_m [1 << PHT_AW];
   btb_entry_t btb_m [1 << BTB_AW];
   pht_idx_t   ghr_m;
   logic       prio_m;

   exp_t     exp_q [$];
   pc_t      rec_pc [$];
   bpu_upd_t rec_upd [$];
   pc_t      pc_pool [12];

   string names [NUM_TESTS];
   int    checks [NUM_TESTS];
   int    errs [NUM_TESTS];
   int    cur_test;
   int    res_issued;
   int    res_grants;
   int    contended;
   int    contended_res1;
   logic  prio_start;

   clk_rst_gen #(.PERIOD_NS(20), .RST_CYCLES(2)) u_clk_rst (.clk, .rst_n);

   bpu_top #(.FETCH_LANES(LANES)) dut_i (
      .clk, .rst_n,
      .req_valid, .req_ready, .req_pc,
      .pred_valid, .pred_ready, .pred_npc, .pred_taken, .pred_upd,
      .res0_valid, .res0_ready, .res0,
      .res1_valid, .res1_ready, .res1
   );

   task automatic check_val(input string name, input logic [63:0] exp_v,
                            input logic [63:0] act_v);
      checks[cur_test]++;
      if (act_v !== exp_v)
      begin
         errs[cur_test]++;
         $display("[FAIL] %s expected 0x%0h actual 0x%0h at %0t", name, exp_v, act_v, $time);
      end
   endtask

   function automatic pht_cnt_t sat_count(input pht_cnt_t c, input logic taken);
      if (taken)
         return (c == 2'd3) ? 2'd3 : c + 2'd1;
      else
         return (c == 2'd0) ? 2'd0 : c - 2'd1;
   endfunction

   function automatic exp_t predict_lookup(input pc_t [LANES-1:0] pcs);
      exp_t       e;
      pht_idx_t   pi;
      btb_idx_t   bi;
      btb_entry_t ent;
      logic       hit;
      for (int l = 0; l < LANES; l++)
      begin
         pi  = pcs[l][PHT_AW-1:0] ^ ghr_m;
         bi  = pcs[l][BTB_AW-1:0];
         ent = btb_m[bi];
         hit = ent.valid && (ent.tag == pcs[l][PC_W-1:BTB_AW]);
         e.pc[l]              = pcs[l];
         e.npc[l]             = ent.target;
         e.upd[l].pht_cnt     = pht_m[pi];
         e.upd[l].pht_idx     = pi;
         e.upd[l].btb_idx     = bi;
         e.upd[l].pred_tgt    = ent.target;
         // Jumps taken on a hit, conditional entries need a counter of 2 or 3
         e.upd[l].pred_taken  = hit && (!ent.is_bcc || (pht_m[pi] >= 2'd2));
      end
      return e;
   endfunction

   task automatic apply_resolve(input bpu_res_t r);
      if (r.is_bcc)
      begin
         pht_m[r.upd.pht_idx] = sat_count(r.upd.pht_cnt, r.taken);
         ghr_m = {ghr_m[PHT_AW-2:0], r.taken};
      end
      if (r.is_breg || r.is_brel)
         btb_m[r.upd.btb_idx] = '{valid: 1'b1, is_bcc: r.is_bcc,
                                  tag: r.pc[PC_W-1:BTB_AW], target: r.npc_act};
   endtask

   function automatic bpu_res_t make_resolve(input logic jump_unit);
      bpu_res_t r;
      int       k;
      k = $urandom_range(0, rec_pc.size() - 1);
      r = '0;
      r.pc  = rec_pc[k];
      r.upd = rec_upd[k];
      if (jump_unit)
      begin
         r.is_breg = 1'($urandom_range(0, 1));
         r.is_brel = !r.is_breg;
         r.taken   = 1'b1;
         r.npc_act = $urandom() & 32'hFFFF_FFFC;
      end
      else
      begin
         r.is_bcc  = 1'b1;
         // A third of the branches are PC-relative and install a BTB entry
         r.is_brel = ($urandom_range(0, 2) == 0);
         r.taken   = 1'($urandom_range(0, 1));
         r.npc_act = r.taken ? ($urandom() & 32'hFFFF_FFFC) : r.pc + 32'd4;
      end
      return r;
   endfunction

   task automatic run_cycle(input int req_pct, input int res0_pct, input int res1_pct,
                            input int stall_pct);
      exp_t               e;
      logic               both;
      pc_t  [LANES-1:0]   pcs;
      @(posedge clk);
      check_val("pred_valid", 64'(exp_q.size() != 0), 64'(pred_valid));
      check_val("req_ready", 64'(exp_q.size() == 0 || pred_ready), 64'(req_ready));
      // Outputs compared every valid cycle, so a stall must hold them
      if (pred_valid && exp_q.size() != 0)
      begin
         e = exp_q[0];
         for (int l = 0; l < LANES; l++)
         begin
            check_val($sformatf("pred_npc[%0d]", l), 64'(e.npc[l]), 64'(pred_npc[l]));
            check_val($sformatf("pred_taken[%0d]", l), 64'(e.upd[l].pred_taken),
                      64'(pred_taken[l]));
            check_val($sformatf("pred_upd[%0d]", l), 64'(e.upd[l]), 64'(pred_upd[l]));
            if (cur_test == 0)
            begin
               check_val("pred_upd.pht_cnt", 64'(1), 64'(pred_upd[l].pht_cnt));
               check_val("pred_upd.pred_taken", 64'(0), 64'(pred_upd[l].pred_taken));
            end
         end
         if (pred_ready)
         begin
            void'(exp_q.pop_front());
            for (int l = 0; l < LANES; l++)
            begin
               rec_pc.push_back(e.pc[l]);
               rec_upd.push_back(e.upd[l]);
            end
            while (rec_pc.size() > POOL_DEPTH)
            begin
               rec_pc.delete(0);
               rec_upd.delete(0);
            end
         end
      end
      // Lookup sees the tables before this edge's resolve write
      if (req_valid && req_ready)
         exp_q.push_back(predict_lookup(req_pc));
      both = res0_valid && res1_valid;
      check_val("res0_ready", 64'(both ? !prio_m : res0_valid), 64'(res0_ready));
      check_val("res1_ready", 64'(both ? prio_m : res1_valid), 64'(res1_ready));
      // A ready with no request behind it shows up as a surplus grant
      res_grants += int'(res0_ready) + int'(res1_ready);
      if (both)
      begin
         prio_m = !prio_m;
         contended++;
         if (res1_ready)
            contended_res1++;
      end
      if (res0_valid && res0_ready)
         apply_resolve(res0);
      if (res1_valid && res1_ready)
         apply_resolve(res1);
      // A request not yet taken stays on the bus unchanged
      if (!req_valid || req_ready)
      begin
         for (int l = 0; l < LANES; l++)
            pcs[l] = pc_pool[$urandom_range(0, 11)];
         req_valid <= ($urandom_range(0, 99) < req_pct);
         req_pc    <= pcs;
      end
      pred_ready <= ($urandom_range(0, 99) >= stall_pct);
      if (!res0_valid || res0_ready)
      begin
         if (rec_pc.size() > 0 && $urandom_range(0, 99) < res0_pct)
         begin
            res0       <= make_resolve(1'b0);
            res0_valid <= 1'b1;
            res_issued++;
         end
         else
            res0_valid <= 1'b0;
      end
      if (!res1_valid || res1_ready)
      begin
         if (rec_pc.size() > 0 && $urandom_range(0, 99) < res1_pct)
         begin
            res1       <= make_resolve(1'b1);
            res1_valid <= 1'b1;
            res_issued++;
         end
         else
            res1_valid <= 1'b0;
      end
   endtask

   task automatic run_test(input int id, input int ncyc, input int req_pct,
                           input int res0_pct, input int res1_pct, input int stall_pct);
      cur_test = id;
      repeat (ncyc) run_cycle(req_pct, res0_pct, res1_pct, stall_pct);
   endtask

   task automatic report_test(input int id);
      $display("%-16s checks %0d errors %0d", names[id], checks[id], errs[id]);
   endtask

   initial
   begin
      int total_checks;
      int total_errs;
      req_valid  = 1'b0;
      req_pc     = '0;
      pred_ready = 1'b0;
      res0_valid = 1'b0;
      res0       = '0;
      res1_valid = 1'b0;
      res1       = '0;
      for (int i = 0; i < (1 << PHT_AW); i++)
         pht_m[i] = PHT_CNT_INIT;
      for (int i = 0; i < (1 << BTB_AW); i++)
         btb_m[i] = '0;
      ghr_m   = '0;
      prio_m  = 1'b0;
      // Four BTB indices only, so tags collide on purpose
      pc_pool = '{32'h0000_1000, 32'h0000_1004, 32'h0000_1010, 32'h0000_1024,
                  32'h0000_1108, 32'h0000_120C, 32'h0000_2000, 32'h0000_2014,
                  32'h0000_3028, 32'h0000_303C, 32'h0000_4100, 32'h0000_4444};
      names = '{"reset_lookup", "jump_target", "cond_branch", "arb_contention",
                "fetch_stall", "random_mix"};
      for (int i = 0; i < NUM_TESTS; i++)
      begin
         checks[i] = 0;
         errs[i]   = 0;
      end
      cur_test       = 0;
      res_issued     = 0;
      res_grants     = 0;
      contended      = 0;
      contended_res1 = 0;
      prio_start     = 1'b0;
      void'($urandom(SEED));
      wait (rst_n === 1'b1);

      run_test(0, 40, 70, 0, 0, 0);
      report_test(0);
      run_test(1, 150, 60, 0, 40, 0);
      report_test(1);
      run_test(2, 300, 60, 50, 10, 0);
      report_test(2);
      contended      = 0;
      contended_res1 = 0;
      prio_start     = prio_m;
      run_test(3, 200, 50, 100, 100, 0);
      // Under contention res1 wins every second cycle from the starting pointer
      check_val("res1_grants", 64'((contended + int'(prio_start)) / 2),
                64'(contended_res1));
      report_test(3);
      run_test(4, 300, 80, 30, 30, 50);
      report_test(4);
      run_test(5, 3000, 60, 40, 30, 25);
      // Let outstanding work finish with no new traffic
      while (res0_valid || res1_valid || req_valid || exp_q.size() != 0)
         run_cycle(0, 0, 0, 0);
      repeat (2) run_cycle(0, 0, 0, 0);
      check_val("res_grants", 64'(res_issued), 64'(res_grants));
      check_val("pending_predictions", 64'(0), 64'(exp_q.size()));
      report_test(5);

      total_checks = 0;
      total_errs   = 0;
      for (int i = 0; i < NUM_TESTS; i++)
      begin
         total_checks += checks[i];
         total_errs   += errs[i];
      end
      $display("Total: %0d checks, %0d errors, %0d resolves granted",
               total_checks, total_errs, res_grants);
      if (total_errs == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

   // Bound on the whole run, four times the stimulus length plus margin
   initial
   begin
      repeat (WD_CYCLES) @(posedge clk);
      $display("Timeout: the run did not finish within %0d clock cycles", WD_CYCLES);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: tb/clk_rst_gen.sv
// Testbench clock source and active-low reset generator
`default_nettype none

module clk_rst_gen #(
   parameter int PERIOD_NS  = 20,
   parameter int RST_CYCLES = 2
) (
   output logic clk,
   output logic rst_n
);
   timeunit 1ns;
   timeprecision 100ps;

   initial
   begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Release on a rising edge, after the DUT flops have seen reset
   initial
   begin
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

`default_nettype wire

// File: vlog.f
rtl/bpu_pkg.sv
rtl/pred_table.sv
rtl/bpu_predict.sv
rtl/bpu_update.sv
rtl/res_arbiter.sv
rtl/bpu_top.sv
tb/clk_rst_gen.sv
tb/bpu_tb.sv
